// File: store_forward.f
design/store_forward_pkg.sv
design/store_buffer.sv
design/data_ram.sv
design/load_merge.sv
design/store_forward.sv
sim/store_forward_assertions.sv
sim/store_forward_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= store_forward_tb
FILELIST ?= store_forward.f
BUILD    ?= obj_dir
LOG      ?= sim.log
FAIL_MSG := Regression failed
PASS_MSG := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	-./$(BUILD)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/store_forward_tb.sv
`default_nettype none

module store_forward_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [7:0]  idx;
        logic [3:0]  mask;
        logic [31:0] data;
        logic [15:0] seq;
    } pend_t;

    localparam int wait_limit = 200;

    logic clk = 1'b0;
    logic rst_n;
    logic flush;
    logic store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    store_forward_pkg::store_op_e store_op;
    logic [15:0] store_seq;
    logic commit_valid;
    logic load_valid;
    logic [31:0] load_addr;
    store_forward_pkg::load_op_e load_op;
    logic [15:0] load_seq;
    logic store_credit;
    logic load_resp_valid;
    logic [31:0] load_resp_data;
    logic load_resp_fwd;

    logic [31:0] ref_mem [store_forward_pkg::ram_words];   // Committed memory
    pend_t       pending [$];                               // Oldest first
    logic [32:0] exp_q [$];                                 // {fwd, data}
    logic [15:0] lfsr;
    logic [15:0] seq_ctr;
    int credits;
    int pulses;
    int checks;
    int errors;
    int test_no;
    int chk_mark;
    int err_mark;

    store_forward u_store_forward (.*);

    always #4 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Committed word, then youngest older pending store per byte, then extract
    function automatic logic [32:0] expected_load(input logic [31:0] addr,
                                                  input store_forward_pkg::load_op_e op,
                                                  input logic [15:0] seq);
        logic [31:0] merged;
        logic [31:0] part;
        logic [3:0]  hit;
        merged = ref_mem[addr[9:2]];
        hit = 4'b0000;
        foreach (pending[i]) begin
            if (pending[i].idx == addr[9:2] && pending[i].seq < seq) begin
                for (int b = 0; b < 4; b++) begin
                    if (pending[i].mask[b]) begin
                        merged[8*b +: 8] = pending[i].data[8*b +: 8];
                        hit[b] = 1'b1;
                    end
                end
            end
        end
        part = merged >> (8 * addr[1:0]);
        case (op)
            store_forward_pkg::ld_byte:   part = {{24{part[7]}}, part[7:0]};
            store_forward_pkg::ld_half:   part = {{16{part[15]}}, part[15:0]};
            store_forward_pkg::ld_byte_u: part = {24'h000000, part[7:0]};
            store_forward_pkg::ld_half_u: part = {16'h0000, part[15:0]};
            default:                      part = merged;
        endcase
        return {|hit, part};
    endfunction

    task automatic report_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic idle_inputs();
        store_valid  = 1'b0;
        commit_valid = 1'b0;
        load_valid   = 1'b0;
        flush        = 1'b0;
    endtask

    task automatic issue_store(input logic [31:0] addr, input logic [31:0] data,
                               input store_forward_pkg::store_op_e op);
        pend_t p;
        int n;
        n = 0;
        while (credits == 0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (credits == 0) begin
            report_timeout("a store credit");
        end else begin
            @(negedge clk);
            idle_inputs();
            store_valid = 1'b1;
            store_addr  = addr;
            store_data  = data;
            store_op    = op;
            store_seq   = seq_ctr;
            p.idx  = addr[9:2];
            p.seq  = seq_ctr;
            p.mask = (op == store_forward_pkg::st_word) ? 4'hf :
                     (op == store_forward_pkg::st_half) ? 4'h3 << addr[1:0] : 4'h1 << addr[1:0];
            p.data = (op == store_forward_pkg::st_word) ? data : data << (8 * addr[1:0]);
            pending.push_back(p);
            seq_ctr++;
            credits--;
        end
    endtask

    task automatic commit_one();
        pend_t p;
        @(negedge clk);
        idle_inputs();
        commit_valid = 1'b1;
        p = pending.pop_front();
        for (int b = 0; b < 4; b++) begin
            if (p.mask[b]) begin
                ref_mem[p.idx][8*b +: 8] = p.data[8*b +: 8];
            end
        end
    endtask

    task automatic issue_load(input logic [31:0] addr, input store_forward_pkg::load_op_e op,
                              input logic [15:0] seq);
        @(negedge clk);
        idle_inputs();
        load_valid = 1'b1;
        load_addr  = addr;
        load_op    = op;
        load_seq   = seq;
        exp_q.push_back(expected_load(addr, op, seq));      // Before this cycle's updates
    endtask

    task automatic new_load(input logic [31:0] addr, input store_forward_pkg::load_op_e op);
        issue_load(addr, op, seq_ctr);
        seq_ctr++;
    endtask

    task automatic load_every_way(input logic [7:0] idx);
        for (int o = 0; o < 4; o++) begin
            new_load({22'b0, idx, o[1:0]}, store_forward_pkg::ld_byte);
            new_load({22'b0, idx, o[1:0]}, store_forward_pkg::ld_byte_u);
            if (o[0] == 1'b0) begin
                new_load({22'b0, idx, o[1:0]}, store_forward_pkg::ld_half);
                new_load({22'b0, idx, o[1:0]}, store_forward_pkg::ld_half_u);
            end
        end
        new_load({22'b0, idx, 2'b00}, store_forward_pkg::ld_word);
    endtask

    task automatic random_load();
        logic [31:0] r;
        store_forward_pkg::load_op_e op;
        r = take_bits(3) % 5;
        case (r)
            0:       op = store_forward_pkg::ld_byte;
            1:       op = store_forward_pkg::ld_half;
            2:       op = store_forward_pkg::ld_word;
            3:       op = store_forward_pkg::ld_byte_u;
            default: op = store_forward_pkg::ld_half_u;
        endcase
        r = take_bits(10);
        if (op == store_forward_pkg::ld_word) begin
            r[1:0] = 2'b00;
        end else if (op == store_forward_pkg::ld_half || op == store_forward_pkg::ld_half_u) begin
            r[0] = 1'b0;                                    // Halves stay aligned
        end
        new_load({22'b0, r[9:0]}, op);
    endtask

    task automatic random_partial(input logic [7:0] idx);
        logic [31:0] r;
        logic [1:0]  off;
        r = take_bits(3);
        off = r[2:1];
        if (r[0]) begin
            off[0] = 1'b0;
            issue_store({22'b0, idx, off}, take_bits(32), store_forward_pkg::st_half);
        end else begin
            issue_store({22'b0, idx, off}, take_bits(32), store_forward_pkg::st_byte);
        end
    endtask

    task automatic drain_commits();
        int n;
        while (pending.size() != 0) begin
            commit_one();
        end
        @(negedge clk);
        idle_inputs();
        n = 0;
        while (credits != store_forward_pkg::sb_depth && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (credits != store_forward_pkg::sb_depth) begin
            report_timeout("returned credits");
        end
    endtask

    task automatic do_flush();
        @(negedge clk);
        idle_inputs();
        flush = 1'b1;
        pending.delete();
        credits = store_forward_pkg::sb_depth;              // Issuer restarts with full credit
    endtask

    task automatic end_test(input string name);
        int n;
        n = 0;
        @(negedge clk);
        idle_inputs();
        while (exp_q.size() != 0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("load responses");
        end else begin
            test_no++;
            $display("Test %0d %s: %0d checks, %0d errors", test_no, name,
                     checks - chk_mark, errors - err_mark);
            chk_mark = checks;
            err_mark = errors;
        end
    endtask

    // Registered outputs sampled at the edge, before they update
    always @(posedge clk) begin
        if (rst_n && store_credit) begin
            credits++;
            pulses++;
        end
    end

    always @(posedge clk) begin
        logic [32:0] e;
        if (rst_n && load_resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Load response at %0t with no load outstanding", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                assert (load_resp_data === e[31:0]) else begin
                    $display("ERROR %0t load_resp_data got %h expected %h",
                             $time, load_resp_data, e[31:0]);
                    errors++;
                end
                assert (load_resp_fwd === e[32]) else begin
                    $display("ERROR %0t load_resp_fwd got %b expected %b",
                             $time, load_resp_fwd, e[32]);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  idx;
        logic [15:0] older;
        int n_st;
        int pulse_mark;
        lfsr       = 16'd76;
        seq_ctr    = 16'd1;
        credits    = store_forward_pkg::sb_depth;
        pulses     = 0;
        checks     = 0;
        errors     = 0;
        test_no    = 0;
        chk_mark   = 0;
        err_mark   = 0;
        rst_n      = 1'b0;
        store_addr = '0;
        store_data = '0;
        store_op   = store_forward_pkg::st_word;
        store_seq  = '0;
        load_addr  = '0;
        load_op    = store_forward_pkg::ld_word;
        load_seq   = '0;
        idle_inputs();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        for (int w = 0; w < store_forward_pkg::ram_words; w++) begin
            issue_store({22'b0, w[7:0], 2'b00}, take_bits(32), store_forward_pkg::st_word);
            commit_one();
        end
        drain_commits();
        repeat (48) random_load();
        end_test("ram only loads");

        r = take_bits(8);
        idx = r[7:0];
        issue_store({22'b0, idx, 2'b00}, take_bits(32), store_forward_pkg::st_word);
        load_every_way(idx);
        drain_commits();
        end_test("full forwarding");

        r = take_bits(8);
        idx = r[7:0];
        issue_store({22'b0, idx, 2'b00}, take_bits(32), store_forward_pkg::st_half);
        issue_store({22'b0, idx, 2'b01}, take_bits(32), store_forward_pkg::st_byte);
        issue_store({22'b0, idx, 2'b11}, take_bits(32), store_forward_pkg::st_byte);
        issue_store({22'b0, idx, 2'b10}, take_bits(32), store_forward_pkg::st_half);
        load_every_way(idx);
        drain_commits();
        repeat (3) begin
            repeat (4) random_partial(idx);
            load_every_way(idx);
            drain_commits();
        end
        end_test("partial merge");

        r = take_bits(8);
        idx = r[7:0];
        older = seq_ctr;                                    // Load older than the store
        seq_ctr++;
        issue_store({22'b0, idx, 2'b00}, take_bits(32), store_forward_pkg::st_word);
        issue_load({22'b0, idx, 2'b00}, store_forward_pkg::ld_word, older);
        issue_load({22'b0, idx, 2'b10}, store_forward_pkg::ld_half, older);
        new_load({22'b0, idx, 2'b00}, store_forward_pkg::ld_word);
        drain_commits();
        end_test("sequence ordering");

        n_st = 0;
        while (credits > 0) begin
            r = take_bits(8);
            issue_store({22'b0, r[7:0], 2'b00}, take_bits(32), store_forward_pkg::st_word);
            n_st++;
        end
        pulse_mark = pulses;
        for (int c = 1; c <= n_st; c++) begin
            commit_one();
            @(negedge clk);
            idle_inputs();
            @(negedge clk);                                 // Pulse lands one cycle after commit
            checks++;
            assert (pulses - pulse_mark == c) else begin
                $display("ERROR %0t store_credit pulses got %0d expected %0d",
                         $time, pulses - pulse_mark, c);
                errors++;
            end
        end
        drain_commits();
        end_test("credits");

        r = take_bits(8);
        idx = r[7:0];
        issue_store({22'b0, idx, 2'b00}, take_bits(32), store_forward_pkg::st_word);
        issue_store({22'b0, idx, 2'b01}, take_bits(32), store_forward_pkg::st_byte);
        do_flush();
        load_every_way(idx);
        repeat (store_forward_pkg::sb_depth) random_partial(idx);
        load_every_way(idx);
        drain_commits();
        end_test("flush");

        errors += u_store_forward.u_store_buffer.u_assertions.fail_count;
        $display("Tests: %0d, checks: %0d, errors: %0d", test_no, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/store_forward_assertions.sv
`default_nettype none

module store_forward_assertions (
    input wire                                 clk,
    input wire                                 rst_n,
    input wire                                 flush,
    input wire                                 store_valid,
    input wire                                 commit_valid,
    input wire                                 store_credit,
    input wire [store_forward_pkg::cnt_w-1:0]  count
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;                                     // Read by the testbench at the end

    store_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid |-> count < store_forward_pkg::sb_depth)
    else begin
        $error("store issued with every buffer entry occupied");
        fail_count++;
    end

    commit_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> count != 0)
    else begin
        $error("commit issued while the store buffer is empty");
        fail_count++;
    end

    // A credit means an entry left the buffer at the previous edge
    credit_needs_commit: assert property (@(posedge clk) disable iff (!rst_n)
        store_credit |-> $past(commit_valid) && !$past(flush) &&
            count == $past(count) + $past(store_valid) - 1)
    else begin
        $error("store_credit pulsed without a commit in the previous cycle");
        fail_count++;
    end

endmodule

bind store_buffer store_forward_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .store_valid  (store_valid),
    .commit_valid (commit_valid),
    .store_credit (store_credit),
    .count        (count)
);

`default_nettype wire

// File: design/store_forward.sv
`default_nettype none

module store_forward (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                flush,
    input  wire                                store_valid,
    input  wire [31:0]                         store_addr,
    input  wire [31:0]                         store_data,
    input  wire store_forward_pkg::store_op_e  store_op,
    input  wire [store_forward_pkg::seq_w-1:0] store_seq,
    input  wire                                commit_valid,
    input  wire                                load_valid,
    input  wire [31:0]                         load_addr,
    input  wire store_forward_pkg::load_op_e   load_op,
    input  wire [store_forward_pkg::seq_w-1:0] load_seq,
    output logic                               store_credit,
    output logic                               load_resp_valid,
    output logic [31:0]                        load_resp_data,
    output logic                               load_resp_fwd
);

    logic                                ram_wr_en;
    logic [store_forward_pkg::idx_w-1:0] ram_wr_addr;
    logic [3:0]                          ram_wr_mask;
    logic [31:0]                         ram_wr_data;
    logic [31:0]                         ram_data;
    logic                                fwd_valid;
    logic [3:0]                          fwd_mask;
    logic [31:0]                         fwd_data;

    store_buffer u_store_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .store_op     (store_op),
        .store_seq    (store_seq),
        .commit_valid (commit_valid),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_seq     (load_seq),
        .store_credit (store_credit),
        .ram_wr_en    (ram_wr_en),
        .ram_wr_addr  (ram_wr_addr),
        .ram_wr_mask  (ram_wr_mask),
        .ram_wr_data  (ram_wr_data),
        .fwd_valid    (fwd_valid),
        .fwd_mask     (fwd_mask),
        .fwd_data     (fwd_data)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_addr (ram_wr_addr),
        .wr_mask (ram_wr_mask),
        .wr_data (ram_wr_data),
        .rd_addr (load_addr[store_forward_pkg::idx_w+1:2]),  // Word index
        .rd_data (ram_data)
    );

    load_merge u_load_merge (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_valid      (load_valid),
        .load_addr_lo    (load_addr[1:0]),
        .load_op         (load_op),
        .fwd_valid       (fwd_valid),
        .fwd_mask        (fwd_mask),
        .fwd_data        (fwd_data),
        .ram_data        (ram_data),
        .load_resp_valid (load_resp_valid),
        .load_resp_data  (load_resp_data),
        .load_resp_fwd   (load_resp_fwd)
    );

endmodule

`default_nettype wire

// File: design/load_merge.sv
`default_nettype none

module load_merge (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               load_valid,
    input  wire [1:0]                         load_addr_lo,
    input  wire store_forward_pkg::load_op_e  load_op,
    input  wire                               fwd_valid,
    input  wire [3:0]                         fwd_mask,
    input  wire [31:0]                        fwd_data,
    input  wire [31:0]                        ram_data,
    output logic                              load_resp_valid,
    output logic [31:0]                       load_resp_data,
    output logic                              load_resp_fwd
);

    store_forward_pkg::load_op_e op_q;
    logic [1:0]                  off_q;
    logic [31:0]                 merged;
    logic [31:0]                 shifted;
    logic [31:0]                 result;

    // Lines up with fwd_valid
    always_ff @(posedge clk) begin
        if (load_valid) begin
            op_q  <= load_op;
            off_q <= load_addr_lo;
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_mask[b] ? fwd_data[8*b +: 8] : ram_data[8*b +: 8];
        end
    end

    assign shifted = merged >> {off_q, 3'b000};

    always_comb begin
        case (op_q)
            store_forward_pkg::ld_byte:   result = {{24{shifted[7]}}, shifted[7:0]};
            store_forward_pkg::ld_half:   result = {{16{shifted[15]}}, shifted[15:0]};
            store_forward_pkg::ld_byte_u: result = {24'h000000, shifted[7:0]};
            store_forward_pkg::ld_half_u: result = {16'h0000, shifted[15:0]};
            default:                      result = merged;     // Word load
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_resp_valid <= 1'b0;
            load_resp_fwd   <= 1'b0;
        end else begin
            load_resp_valid <= fwd_valid;
            load_resp_fwd   <= fwd_valid && (|fwd_mask);
        end
    end

    always_ff @(posedge clk) begin
        load_resp_data <= result;
    end

endmodule

`default_nettype wire

// File: design/data_ram.sv
`default_nettype none

module data_ram (
    input  wire                                 clk,
    input  wire                                 wr_en,
    input  wire [store_forward_pkg::idx_w-1:0]  wr_addr,
    input  wire [3:0]                           wr_mask,
    input  wire [31:0]                          wr_data,
    input  wire [store_forward_pkg::idx_w-1:0]  rd_addr,
    output logic [31:0]                         rd_data
);

    logic [31:0] mem [store_forward_pkg::ram_words];

    // Byte-enable commit write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Old word on a same-edge collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: design/store_buffer.sv
`default_nettype none

module store_buffer (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   flush,
    input  wire                                   store_valid,
    input  wire [31:0]                            store_addr,
    input  wire [31:0]                            store_data,
    input  wire store_forward_pkg::store_op_e     store_op,
    input  wire [store_forward_pkg::seq_w-1:0]    store_seq,
    input  wire                                   commit_valid,
    input  wire                                   load_valid,
    input  wire [31:0]                            load_addr,
    input  wire [store_forward_pkg::seq_w-1:0]    load_seq,
    output logic                                  store_credit,
    output logic                                  ram_wr_en,
    output logic [store_forward_pkg::idx_w-1:0]   ram_wr_addr,
    output logic [3:0]                            ram_wr_mask,
    output logic [31:0]                           ram_wr_data,
    output logic                                  fwd_valid,
    output logic [3:0]                            fwd_mask,
    output logic [31:0]                           fwd_data
);

    logic [store_forward_pkg::sb_depth-1:0] ent_valid;
    logic [store_forward_pkg::idx_w-1:0]    ent_idx  [store_forward_pkg::sb_depth];
    logic [3:0]                             ent_mask [store_forward_pkg::sb_depth];
    logic [31:0]                            ent_data [store_forward_pkg::sb_depth];
    logic [store_forward_pkg::seq_w-1:0]    ent_seq  [store_forward_pkg::sb_depth];

    logic [store_forward_pkg::ptr_w-1:0] head;
    logic [store_forward_pkg::ptr_w-1:0] tail;
    logic [store_forward_pkg::cnt_w-1:0] count;

    logic        store_ok;
    logic        commit_ok;
    logic [3:0]  new_mask;
    logic [31:0] new_data;
    logic [3:0]  lk_mask;
    logic [31:0] lk_data;

    assign store_ok  = store_valid && (count < store_forward_pkg::sb_depth);
    assign commit_ok = commit_valid && (count != 0);

    // Lane-aligned mask and data for the incoming store
    always_comb begin
        case (store_op)
            store_forward_pkg::st_byte: begin
                new_mask = 4'b0001 << store_addr[1:0];
                new_data = {4{store_data[7:0]}};
            end
            store_forward_pkg::st_half: begin
                new_mask = 4'b0011 << {store_addr[1], 1'b0};
                new_data = {2{store_data[15:0]}};
            end
            store_forward_pkg::st_word: begin
                new_mask = 4'b1111;
                new_data = store_data;
            end
            default: begin
                new_mask = 4'b0000;
                new_data = store_data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_valid    <= '0;
            store_credit <= 1'b0;
        end else begin
            store_credit <= commit_ok && !flush;            // No credits back on flush
            if (flush) begin
                head      <= '0;
                tail      <= '0;
                count     <= '0;
                ent_valid <= '0;
            end else begin
                if (store_ok) begin
                    ent_valid[tail] <= 1'b1;
                    tail            <= tail + 1'b1;
                end
                if (commit_ok) begin
                    ent_valid[head] <= 1'b0;
                    head            <= head + 1'b1;
                end
                case ({store_ok, commit_ok})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_ok) begin
            ent_idx[tail]  <= store_addr[store_forward_pkg::idx_w+1:2];
            ent_mask[tail] <= new_mask;
            ent_data[tail] <= new_data;
            ent_seq[tail]  <= store_seq;
        end
    end

    // Commit drains the head entry
    assign ram_wr_en   = commit_ok;
    assign ram_wr_addr = ent_idx[head];
    assign ram_wr_mask = ent_mask[head];
    assign ram_wr_data = ent_data[head];

    // Oldest to youngest, so the youngest older store wins each lane
    always_comb begin
        logic [store_forward_pkg::ptr_w-1:0] slot;
        lk_mask = '0;
        lk_data = '0;
        slot    = head;
        for (int k = 0; k < store_forward_pkg::sb_depth; k++) begin
            if (ent_valid[slot] && ent_idx[slot] == load_addr[store_forward_pkg::idx_w+1:2] &&
                ent_seq[slot] < load_seq) begin
                for (int b = 0; b < 4; b++) begin
                    if (ent_mask[slot][b]) begin
                        lk_mask[b]         = 1'b1;
                        lk_data[8*b +: 8]  = ent_data[slot][8*b +: 8];
                    end
                end
            end
            slot = slot + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= load_valid;
        end
    end

    always_ff @(posedge clk) begin
        fwd_mask <= lk_mask;
        fwd_data <= lk_data;
    end

endmodule

`default_nettype wire

// File: design/store_forward_pkg.sv
`default_nettype none

package store_forward_pkg;

    // Store buffer
    localparam int unsigned sb_depth = 8;                   // Entries and initial credits
    localparam int unsigned ptr_w = $clog2(sb_depth);
    localparam int unsigned cnt_w = $clog2(sb_depth + 1);

    // Data RAM
    localparam int unsigned ram_words = 256;
    localparam int unsigned idx_w = $clog2(ram_words);      // Word index, address bits 9:2

    localparam int unsigned seq_w = 16;

    // Store opcodes follow funct3
    typedef enum logic [2:0] {
        st_byte = 3'b000,
        st_half = 3'b001,
        st_word = 3'b010
    } store_op_e;

    // Load opcodes follow funct3
    typedef enum logic [2:0] {
        ld_byte   = 3'b000,
        ld_half   = 3'b001,
        ld_word   = 3'b010,
        ld_byte_u = 3'b100,
        ld_half_u = 3'b101
    } load_op_e;

endpackage

`default_nettype wire
